// ==== framebuffer_display.f ====
source/fb_pkg.sv
source/display_timings.sv
source/bram_sdp.sv
source/fb_reader.sv
source/clut_regs.sv
source/pixel_colour.sv
source/framebuffer_top.sv
dv/tb_framebuffer.sv

// ==== Makefile ====
# Verilator build and run of the framebuffer display testbench

VERILATOR ?= verilator
TOP       ?= tb_framebuffer
FILELIST  ?= framebuffer_display.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_framebuffer.sv ====
/* framebuffer display testbench with clock, reset, random image and palette,
   reference model, comparing process, compare tasks and timeout */

`timescale 1ns/1ps

module tb_framebuffer;

    localparam int FRAME_CYCLES   = fb_pkg::H_FULL * fb_pkg::V_FULL;     // 420000
    localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 40_000 + 200_000; // 1.5M
    localparam int HS_START       = fb_pkg::H_RES + fb_pkg::H_FP;        // 656
    localparam int VS_START       = fb_pkg::V_RES + fb_pkg::V_FP;        // 490
    localparam int LAG            = 3;  // vga behind pos
    localparam int VISIBLE        = fb_pkg::H_RES * fb_pkg::V_RES;

    logic            clk_pix;
    logic            rst_n;
    fb_pkg::cfg_wr_t cfg;
    fb_pkg::vga_t    vga;

    // host's view of what has been written
    fb_pkg::rgb12_t    model_pal [16];
    fb_pkg::rgb12_t    model_bg;
    fb_pkg::colr_idx_t model_img [fb_pkg::FB_PIXELS];

    int    col;                  // position of the sample on vga
    int    line;
    logic  h_lock;
    logic  v_lock;
    logic  prev_hs;
    logic  prev_vs;
    logic  check_en;             // visible colours compared
    int    frames_done     = 0;  // visible areas fully compared
    int    visible_checked = 0;
    int    cycles          = 0;
    string phase;

    framebuffer_top framebuffer_top_i (
        .clk_pix,
        .rst_n,
        .cfg,
        .vga
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;  // 4 ns
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_vga(input string name, input fb_pkg::vga_t exp,
                             input fb_pkg::vga_t act);
        if (act !== exp) begin
            fail_now($sformatf(
                "CHECK FAILED %s: expected hs=%b vs=%b rgb=%h, actual hs=%b vs=%b rgb=%h",
                name, exp.hsync, exp.vsync, exp.rgb,
                act.hsync, act.vsync, act.rgb));
        end
    endtask

    task automatic check_rgb(input string name, input fb_pkg::rgb12_t exp,
                             input fb_pkg::rgb12_t act);
        if (act !== exp) begin
            fail_now($sformatf("CHECK FAILED %s at col %0d line %0d: expected %h, actual %h",
                               name, col, line, exp, act));
        end
    endtask

    // expected output for one screen position from the model copy
    function automatic fb_pkg::vga_t ref_vga(input int c, input int l);
        fb_pkg::vga_t v;
        v.hsync = !((c >= HS_START) && (c < HS_START + fb_pkg::H_SYNC));
        v.vsync = !((l >= VS_START) && (l < VS_START + fb_pkg::V_SYNC));
        if ((c < fb_pkg::FB_WIDTH) && (l < fb_pkg::FB_HEIGHT)) begin
            v.rgb = model_pal[model_img[l * fb_pkg::FB_WIDTH + c]];  // 1:1 top left
        end else if ((c < fb_pkg::H_RES) && (l < fb_pkg::V_RES)) begin
            v.rgb = model_bg;
        end else begin
            v.rgb = '0;  // blanking
        end
        return v;
    endfunction

    // host writes one per cycle and the model follows at drive time
    task automatic write_pixel(input int addr, input fb_pkg::colr_idx_t idx);
        fb_pkg::cfg_wr_t w;
        w.we           = 1'b1;
        w.sel          = fb_pkg::SEL_PIXEL;
        w.addr         = fb_pkg::fb_addr_t'(addr);
        w.data.pix.pad = 8'($urandom());  // junk the RTL must ignore
        w.data.pix.idx = idx;
        @(posedge clk_pix);
        cfg <= w;
        model_img[addr] = idx;
    endtask

    task automatic write_palette(input int entry, input fb_pkg::rgb12_t colr);
        fb_pkg::cfg_wr_t w;
        w.we        = 1'b1;
        w.sel       = fb_pkg::SEL_PALETTE;
        w.addr      = fb_pkg::fb_addr_t'(entry);  // entry in low 4 bits
        w.data.colr = colr;
        @(posedge clk_pix);
        cfg <= w;
        model_pal[entry] = colr;
    endtask

    task automatic write_background(input fb_pkg::rgb12_t colr);
        fb_pkg::cfg_wr_t w;
        w.we        = 1'b1;
        w.sel       = fb_pkg::SEL_BACKGROUND;
        w.addr      = '0;
        w.data.colr = colr;
        @(posedge clk_pix);
        cfg <= w;
        model_bg = colr;
    endtask

    task automatic bus_idle();
        @(posedge clk_pix);
        cfg <= '0;
    endtask

    task automatic compare_pixel(input int c, input int l);
        fb_pkg::vga_t exp;
        exp = ref_vga(c, l);
        if ((c < fb_pkg::H_RES) && (l < fb_pkg::V_RES)) begin
            if ((vga.hsync !== 1'b1) || (vga.vsync !== 1'b1)) begin
                fail_now($sformatf("sync pulse active in the visible area at col %0d line %0d",
                                   c, l));
            end
            if (check_en) begin
                if ((c < fb_pkg::FB_WIDTH) && (l < fb_pkg::FB_HEIGHT)) begin
                    check_rgb({phase, ", framebuffer pixel"}, exp.rgb, vga.rgb);
                end else begin
                    check_rgb({phase, ", background"}, exp.rgb, vga.rgb);
                end
                visible_checked++;
            end
        end else begin
            check_vga("sync timing and blanking", exp, vga);  // syncs + black
        end
    endtask

    // comparing process samples mid-cycle where vga is stable
    always @(negedge clk_pix) begin
        if (!rst_n) begin
            h_lock  = 1'b0;
            v_lock  = 1'b0;
            prev_hs = 1'b1;
            prev_vs = 1'b1;
        end else begin
            if (h_lock) begin
                if (col == fb_pkg::H_FULL - 1) begin
                    col  = 0;
                    line = (line == fb_pkg::V_FULL - 1) ? 0 : line + 1;
                end else begin
                    col = col + 1;
                end
            end
            if (!h_lock && prev_hs && !vga.hsync) begin
                h_lock = 1'b1;  // hsync fall is column 656
                col    = HS_START;
            end
            if (h_lock && !v_lock && prev_vs && !vga.vsync) begin
                if (col != 0) begin
                    fail_now($sformatf("vsync fell at column %0d instead of a line start", col));
                end
                v_lock = 1'b1;  // first vsync-low line is 490
                line   = VS_START;
            end
            if (v_lock) begin
                compare_pixel(col, line);
                if (check_en && (col == 0) && (line == fb_pkg::V_RES)) begin
                    frames_done++;  // visible area just finished
                end
            end
            prev_hs = vga.hsync;
            prev_vs = vga.vsync;
        end
    end

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            fail_now($sformatf("run timed out after %0d cycles", cycles));
        end
    end

    initial begin
        fb_pkg::vga_t exp;
        fb_pkg::vga_t idle;  // syncs inactive, colour black
        void'($urandom(69610));
        rst_n      = 1'b0;
        cfg        = '0;
        check_en   = 1'b0;
        phase      = "startup";
        idle.hsync = 1'b1;
        idle.vsync = 1'b1;
        idle.rgb   = '0;
        model_bg   = '0;
        for (int i = 0; i < 16; i++) begin
            model_pal[i] = '0;
        end
        for (int i = 0; i < fb_pkg::FB_PIXELS; i++) begin
            model_img[i] = '0;
        end

        @(posedge clk_pix);
        @(negedge clk_pix);
        check_vga("reset state", idle, vga);  // still held in reset
        @(posedge clk_pix);
        rst_n <= 1'b1;  // two cycles low

        // reset state then line 0 up to the first hsync fall 659 cycles on
        for (int n = 0; n <= HS_START + LAG; n++) begin
            @(negedge clk_pix);
            if (n < LAG) begin
                exp = idle;
            end else begin
                exp = ref_vga(n - LAG, 0);
            end
            check_vga((n < LAG) ? "reset state" : "first hsync edge", exp, vga);
        end

        // random palette, background and a full image
        phase = "image display";
        for (int e = 0; e < 16; e++) begin
            write_palette(e, 12'($urandom()));
        end
        write_background(12'($urandom()));
        for (int a = 0; a < fb_pkg::FB_PIXELS; a++) begin
            write_pixel(a, 4'($urandom_range(15, 0)));
        end
        bus_idle();
        check_en = 1'b1;
        wait (frames_done == 1);

        // in vertical blanking now so rewrite colours and a few pixels
        phase = "live update";
        for (int k = 0; k < 4; k++) begin
            write_palette($urandom_range(15, 0), 12'($urandom()));
        end
        write_background(12'($urandom()));
        write_pixel(0, 4'($urandom_range(15, 0)));
        write_pixel(fb_pkg::FB_PIXELS - 1, 4'($urandom_range(15, 0)));  // last corner
        for (int k = 0; k < 20; k++) begin
            write_pixel($urandom_range(fb_pkg::FB_PIXELS - 1, 0), 4'($urandom_range(15, 0)));
        end
        bus_idle();
        wait (frames_done == 2);

        if (visible_checked < 2 * VISIBLE) begin
            fail_now($sformatf("only %0d visible pixels were compared", visible_checked));
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

// ==== source/framebuffer_top.sv ====
/* indexed-colour framebuffer display top
   timing, reader, RAM, colour registers and output stage */

`timescale 1ns/1ps

module framebuffer_top (
    input  logic            clk_pix,
    input  logic            rst_n,
    input  fb_pkg::cfg_wr_t cfg,
    output fb_pkg::vga_t    vga
);

    fb_pkg::screen_pos_t pos;
    fb_pkg::fb_addr_t    rd_addr;
    fb_pkg::pix_flags_t  flags;
    fb_pkg::colr_idx_t   rd_data;   // index read from framebuffer
    fb_pkg::rgb12_t      palette [2**fb_pkg::FB_DATAW];
    fb_pkg::rgb12_t      background;
    logic                pix_we;    // host pixel write

    always_comb begin
        pix_we = cfg.we && (cfg.sel == fb_pkg::SEL_PIXEL);
    end

    display_timings display_timings_i (
        .clk_pix,
        .rst_n,
        .pos
    );

    fb_reader fb_reader_i (
        .clk_pix,
        .rst_n,
        .pos,
        .rd_addr,
        .flags
    );

    bram_sdp #(
        .WIDTH(fb_pkg::FB_DATAW),
        .DEPTH(fb_pkg::FB_PIXELS)
    ) bram_sdp_i (
        .clk_pix,
        .we(pix_we),
        .wr_addr(cfg.addr),
        .wr_data(cfg.data.pix.idx),  // index view of host word
        .rd_addr,
        .rd_data
    );

    clut_regs clut_regs_i (
        .clk_pix,
        .rst_n,
        .cfg,
        .palette,
        .background
    );

    pixel_colour pixel_colour_i (
        .clk_pix,
        .rst_n,
        .flags,
        .rd_data,
        .palette,
        .background,
        .vga
    );

endmodule

// ==== source/pixel_colour.sv ====
/* palette lookup, region select, blanking
   and the registered VGA output */

`timescale 1ns/1ps

module pixel_colour (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  fb_pkg::pix_flags_t flags,
    input  fb_pkg::colr_idx_t  rd_data,
    input  fb_pkg::rgb12_t     palette [2**fb_pkg::FB_DATAW],
    input  fb_pkg::rgb12_t     background,
    output fb_pkg::vga_t       vga
);

    fb_pkg::rgb12_t colr;  // selected colour this cycle

    // framebuffer wins, then background, else black
    always_comb begin
        if (flags.in_fb) begin
            colr = palette[rd_data];   // clut lookup
        end else if (flags.de) begin
            colr = background;         // visible, outside region
        end else begin
            colr = '0;                 // blanking
        end
    end

    // output register keeps syncs and colour aligned
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            vga.hsync <= 1'b1;
            vga.vsync <= 1'b1;
            vga.rgb   <= '0;
        end else begin
            vga.hsync <= flags.hsync;
            vga.vsync <= flags.vsync;
            vga.rgb   <= colr;
        end
    end

endmodule

// ==== source/clut_regs.sv ====
/* palette and background colour registers
   written from the host port using the colour view of the data */

`timescale 1ns/1ps

module clut_regs (
    input  logic            clk_pix,
    input  logic            rst_n,
    input  fb_pkg::cfg_wr_t cfg,
    output fb_pkg::rgb12_t  palette [2**fb_pkg::FB_DATAW],
    output fb_pkg::rgb12_t  background
);

    logic             pal_we;   // palette entry write
    logic             bg_we;    // background write
    fb_pkg::colr_idx_t pal_idx;

    always_comb begin
        pal_we  = cfg.we && (cfg.sel == fb_pkg::SEL_PALETTE);
        bg_we   = cfg.we && (cfg.sel == fb_pkg::SEL_BACKGROUND);
        pal_idx = cfg.addr[fb_pkg::FB_DATAW-1:0];  // entry number in low bits
        // SEL_PIXEL writes go to the RAM, not here
    end

    // 16-entry lookup table
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**fb_pkg::FB_DATAW; i++) begin
                palette[i] <= '0;  // black
            end
        end else if (pal_we) begin
            palette[pal_idx] <= cfg.data.colr;
        end
    end

    // colour outside the framebuffer region
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            background <= '0;
        end else if (bg_we) begin
            background <= cfg.data.colr;
        end
    end

endmodule

// ==== source/fb_reader.sv ====
/* framebuffer read address counter
   and two-stage flag pipeline matching the RAM read */

`timescale 1ns/1ps

module fb_reader (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  fb_pkg::screen_pos_t pos,
    output fb_pkg::fb_addr_t    rd_addr,
    output fb_pkg::pix_flags_t  flags
);

    logic               in_fb_now;   // current pos inside region
    logic               frame_last;  // final position of the frame
    fb_pkg::fb_addr_t   addr_cnt;    // index of current pos when in_fb_now
    fb_pkg::pix_flags_t flags_q;     // lags pos by one, same as rd_addr

    always_comb begin
        in_fb_now  = (pos.sx < fb_pkg::FB_WIDTH) && (pos.sy < fb_pkg::FB_HEIGHT);
        frame_last = (pos.sx == fb_pkg::H_FULL - 1) && (pos.sy == fb_pkg::V_FULL - 1);
    end

    // walks rows of 160 by counting only region positions
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            addr_cnt <= '0;
        end else if (frame_last) begin
            addr_cnt <= '0;
        end else if (in_fb_now) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    // address issued one cycle after pos
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            rd_addr <= '0;
        end else if (in_fb_now) begin
            rd_addr <= addr_cnt;
        end
    end

    // first flag stage, alongside rd_addr
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            flags_q.hsync <= 1'b1;
            flags_q.vsync <= 1'b1;
            flags_q.de    <= 1'b0;
            flags_q.in_fb <= 1'b0;
        end else begin
            flags_q.hsync <= pos.hsync;
            flags_q.vsync <= pos.vsync;
            flags_q.de    <= pos.de;
            flags_q.in_fb <= in_fb_now;
        end
    end

    // second stage lines up with rd_data from the RAM
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            flags.hsync <= 1'b1;
            flags.vsync <= 1'b1;
            flags.de    <= 1'b0;
            flags.in_fb <= 1'b0;
        end else begin
            flags <= flags_q;
        end
    end

endmodule

// ==== source/bram_sdp.sv ====
/* simple dual-port block RAM
   one write port, registered read port */

`timescale 1ns/1ps

module bram_sdp #(
    parameter int WIDTH = 4,
    parameter int DEPTH = 19200
) (
    input  logic                     clk_pix,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    // start with a blank image, index 0 everywhere
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // one cycle read latency
    end

endmodule

// ==== source/display_timings.sv ====
/* screen position counters for 800x525 frame
   with registered sync and display enable */

`timescale 1ns/1ps

module display_timings (
    input  logic                clk_pix,
    input  logic                rst_n,
    output fb_pkg::screen_pos_t pos
);

    fb_pkg::coord_t sx_nxt;   // position for next cycle
    fb_pkg::coord_t sy_nxt;
    logic           line_end;
    logic           frame_end;
    logic           hsync_nxt;
    logic           vsync_nxt;
    logic           de_nxt;

    always_comb begin
        line_end  = (pos.sx == fb_pkg::H_FULL - 1);
        frame_end = line_end && (pos.sy == fb_pkg::V_FULL - 1);

        if (line_end) begin
            sx_nxt = '0;
            sy_nxt = frame_end ? '0 : pos.sy + 1'b1;  // wrap at 524
        end else begin
            sx_nxt = pos.sx + 1'b1;
            sy_nxt = pos.sy;
        end
    end

    // decode levels from the next position so they line up with it
    always_comb begin
        hsync_nxt = !((sx_nxt >= fb_pkg::H_RES + fb_pkg::H_FP) &&
                      (sx_nxt <  fb_pkg::H_RES + fb_pkg::H_FP + fb_pkg::H_SYNC));  // 656..751
        vsync_nxt = !((sy_nxt >= fb_pkg::V_RES + fb_pkg::V_FP) &&
                      (sy_nxt <  fb_pkg::V_RES + fb_pkg::V_FP + fb_pkg::V_SYNC));  // 490..491
        de_nxt    = (sx_nxt < fb_pkg::H_RES) && (sy_nxt < fb_pkg::V_RES);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            pos.sx    <= '0;
            pos.sy    <= '0;
            pos.hsync <= 1'b1;  // syncs idle high
            pos.vsync <= 1'b1;
            pos.de    <= 1'b1;  // (0,0) is visible
        end else begin
            pos.sx    <= sx_nxt;
            pos.sy    <= sy_nxt;
            pos.hsync <= hsync_nxt;
            pos.vsync <= vsync_nxt;
            pos.de    <= de_nxt;
        end
    end

endmodule

// ==== source/fb_pkg.sv ====
/* shared timing constants, framebuffer sizes
   and the struct, enum and union types used across the display */

package fb_pkg;

    // horizontal timing in pixel periods
    localparam int H_RES  = 640;
    localparam int H_FP   = 16;   // front porch
    localparam int H_SYNC = 96;
    localparam int H_BP   = 48;   // back porch
    localparam int H_FULL = H_RES + H_FP + H_SYNC + H_BP;  // 800

    // vertical timing in lines
    localparam int V_RES  = 480;
    localparam int V_FP   = 10;
    localparam int V_SYNC = 2;
    localparam int V_BP   = 33;
    localparam int V_FULL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    localparam int CORDW = 10;  // screen coordinate width

    // framebuffer geometry
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 19200
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);     // 15
    localparam int FB_DATAW  = 4;                     // bits per index

    typedef logic [CORDW-1:0]    coord_t;
    typedef logic [FB_ADDRW-1:0] fb_addr_t;   // row*160 + column
    typedef logic [FB_DATAW-1:0] colr_idx_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb12_t;

    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;  // active low
        logic   vsync;  // active low
        logic   de;
    } screen_pos_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        logic in_fb;    // inside 160x120 region
    } pix_flags_t;

    typedef enum logic [1:0] {
        SEL_PIXEL      = 2'd0,
        SEL_PALETTE    = 2'd1,
        SEL_BACKGROUND = 2'd2
    } cfg_sel_e;

    // host data word, colour or pixel index depending on sel
    typedef union packed {
        rgb12_t colr;
        struct packed {
            logic [7:0] pad;  // unused
            colr_idx_t  idx;
        } pix;
    } cfg_data_u;

    typedef struct packed {
        logic      we;
        cfg_sel_e  sel;
        fb_addr_t  addr;   // palette entry in low bits
        cfg_data_u data;
    } cfg_wr_t;

    typedef struct packed {
        logic   hsync;
        logic   vsync;
        rgb12_t rgb;
    } vga_t;

endpackage
